// ==== verilog/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and pc width
`define XLEN 64

// architectural integer registers
`define NUM_REGS 32

`define RESET_PC 64'h8000_0000

// rv64i major opcodes
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP        7'b0110011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_OP_32     7'b0111011

`endif

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // branch offset bits scattered over the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_t;

    // one-hot alu operation, bit positions below
    typedef logic [10:0] alu_op_t;

    localparam int unsigned ALU_ADD  = 0;
    localparam int unsigned ALU_SUB  = 1;
    localparam int unsigned ALU_SLL  = 2;
    localparam int unsigned ALU_SLT  = 3;
    localparam int unsigned ALU_SLTU = 4;
    localparam int unsigned ALU_XOR  = 5;
    localparam int unsigned ALU_SRL  = 6;
    localparam int unsigned ALU_SRA  = 7;
    localparam int unsigned ALU_OR   = 8;
    localparam int unsigned ALU_AND  = 9;
    localparam int unsigned ALU_LUI  = 10;

endpackage

// ==== verilog/exu_ctrl_if.sv ====
`timescale 1ns/1ps

interface exu_ctrl_if import rv_pkg::*; ();

    alu_op_t     alu_op;
    // reg, pc
    logic [1:0]  sel_alusrc1;
    // reg, imm_i, imm_u
    logic [2:0]  sel_alusrc2;
    // full, word sign-extended
    logic [1:0]  sel_alures;
    // seq, jal, jalr, beq, bne, blt, bge
    logic [6:0]  sel_nextpc;

    logic [11:0] imm_i;
    logic [20:0] imm_j;
    logic [19:0] imm_u;
    logic [12:0] imm_b;

    modport dec (
        output alu_op, sel_alusrc1, sel_alusrc2, sel_alures, sel_nextpc,
        output imm_i, imm_j, imm_u, imm_b
    );

    modport exe (
        input  alu_op, sel_alusrc1, sel_alusrc2, sel_alures, sel_nextpc,
        input  imm_i, imm_j, imm_u, imm_b
    );

endinterface

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module alu import rv_pkg::*; (
    input  alu_op_t           alu_op,
    input  logic [`XLEN-1:0]  src1,
    input  logic [`XLEN-1:0]  src2,
    input  logic              word,
    output logic [`XLEN-1:0]  result
);

    logic [5:0]        shamt;
    logic [`XLEN-1:0]  src1_w_zext;
    logic [`XLEN-1:0]  src1_w_sext;
    logic [`XLEN-1:0]  sum;
    logic [`XLEN-1:0]  diff;
    logic [`XLEN-1:0]  sll_res;
    logic [`XLEN-1:0]  srl_res;
    logic [`XLEN-1:0]  sra_res;
    logic [`XLEN-1:0]  slt_res;
    logic [`XLEN-1:0]  sltu_res;

    // word shifts take 5-bit amounts on the low half
    assign shamt       = word ? {1'b0, src2[4:0]} : src2[5:0];
    assign src1_w_zext = {{(`XLEN-32){1'b0}}, src1[31:0]};
    assign src1_w_sext = {{(`XLEN-32){src1[31]}}, src1[31:0]};

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    // low 32 bits already right for sllw
    assign sll_res = src1 << shamt;
    assign srl_res = word ? (src1_w_zext >> shamt) : (src1 >> shamt);
    assign sra_res = word ? `XLEN'($signed(src1_w_sext) >>> shamt)
                          : `XLEN'($signed(src1) >>> shamt);

    assign slt_res  = {{(`XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
    assign sltu_res = {{(`XLEN-1){1'b0}}, src1 < src2};

    assign result = ({`XLEN{alu_op[ALU_ADD]}}  & sum)
                  | ({`XLEN{alu_op[ALU_SUB]}}  & diff)
                  | ({`XLEN{alu_op[ALU_SLL]}}  & sll_res)
                  | ({`XLEN{alu_op[ALU_SLT]}}  & slt_res)
                  | ({`XLEN{alu_op[ALU_SLTU]}} & sltu_res)
                  | ({`XLEN{alu_op[ALU_XOR]}}  & (src1 ^ src2))
                  | ({`XLEN{alu_op[ALU_SRL]}}  & srl_res)
                  | ({`XLEN{alu_op[ALU_SRA]}}  & sra_res)
                  | ({`XLEN{alu_op[ALU_OR]}}   & (src1 | src2))
                  | ({`XLEN{alu_op[ALU_AND]}}  & (src1 & src2))
                  | ({`XLEN{alu_op[ALU_LUI]}}  & src2);

endmodule

// ==== verilog/idu.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module idu import rv_pkg::*; (
    input  inst_t       inst,
    exu_ctrl_if.dec     ctrl,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    output logic [4:0]  rd_addr,
    output logic        rf_wen,
    output logic        link
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    alu_op_t    op;
    logic [1:0] sel_src1;
    logic [2:0] sel_src2;
    logic [1:0] sel_res;
    logic [6:0] sel_npc;
    logic       writes;

    function automatic alu_op_t op_bit(input int unsigned idx);
        op_bit      = '0;
        op_bit[idx] = 1'b1;
    endfunction

    // shared funct3 map for op and op-imm, sub only exists for op
    function automatic alu_op_t op_from_funct3(input logic [2:0] f3, input logic f7_alt,
                                               input logic is_reg);
        case (f3)
            3'b000:  op_from_funct3 = (is_reg && f7_alt) ? op_bit(ALU_SUB) : op_bit(ALU_ADD);
            3'b001:  op_from_funct3 = op_bit(ALU_SLL);
            3'b010:  op_from_funct3 = op_bit(ALU_SLT);
            3'b011:  op_from_funct3 = op_bit(ALU_SLTU);
            3'b100:  op_from_funct3 = op_bit(ALU_XOR);
            3'b101:  op_from_funct3 = f7_alt ? op_bit(ALU_SRA) : op_bit(ALU_SRL);
            3'b110:  op_from_funct3 = op_bit(ALU_OR);
            default: op_from_funct3 = op_bit(ALU_AND);
        endcase
    endfunction

    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;
    assign alt    = inst.r.funct7[5];

    always_comb begin
        op       = op_bit(ALU_ADD);
        sel_src1 = 2'b01;
        sel_src2 = 3'b001;
        sel_res  = 2'b01;
        sel_npc  = 7'b0000001;
        writes   = 1'b0;
        link     = 1'b0;
        case (opcode)
            `OPC_LUI: begin
                op       = op_bit(ALU_LUI);
                sel_src2 = 3'b100;
                writes   = 1'b1;
            end
            `OPC_AUIPC: begin
                sel_src1 = 2'b10;
                sel_src2 = 3'b100;
                writes   = 1'b1;
            end
            `OPC_JAL: begin
                sel_npc = 7'b0000010;
                writes  = 1'b1;
                link    = 1'b1;
            end
            `OPC_JALR: begin
                sel_npc = 7'b0000100;
                writes  = 1'b1;
                link    = 1'b1;
            end
            `OPC_BRANCH: begin
                case (funct3)
                    3'b000:  sel_npc = 7'b0001000;
                    3'b001:  sel_npc = 7'b0010000;
                    3'b100:  sel_npc = 7'b0100000;
                    3'b101:  sel_npc = 7'b1000000;
                    default: sel_npc = 7'b0000001;
                endcase
            end
            `OPC_OP_IMM: begin
                op       = op_from_funct3(funct3, alt, 1'b0);
                sel_src2 = 3'b010;
                writes   = 1'b1;
            end
            `OPC_OP: begin
                op     = op_from_funct3(funct3, alt, 1'b1);
                writes = 1'b1;
            end
            `OPC_OP_IMM_32: begin
                // addiw only
                sel_src2 = 3'b010;
                sel_res  = 2'b10;
                writes   = (funct3 == 3'b000);
            end
            `OPC_OP_32: begin
                op      = alt ? op_bit(ALU_SUB) : op_bit(ALU_ADD);
                sel_res = 2'b10;
                writes  = (funct3 == 3'b000);
            end
            default: ;
        endcase
    end

    assign ctrl.alu_op      = op;
    assign ctrl.sel_alusrc1 = sel_src1;
    assign ctrl.sel_alusrc2 = sel_src2;
    assign ctrl.sel_alures  = sel_res;
    assign ctrl.sel_nextpc  = sel_npc;

    // raw immediates through the format views
    assign ctrl.imm_i = inst.i.imm;
    assign ctrl.imm_u = inst.u.imm;
    assign ctrl.imm_b = {inst.b.imm_12, inst.b.imm_11, inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    assign ctrl.imm_j = {inst.j.imm_20, inst.j.imm_19_12, inst.j.imm_11, inst.j.imm_10_1, 1'b0};

    assign rs1_addr = inst.r.rs1;
    assign rs2_addr = inst.r.rs2;
    assign rd_addr  = inst.r.rd;

    // x0 writes dropped here
    assign rf_wen = writes && (inst.r.rd != 5'd0);

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module regfile (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [4:0]        rs1_addr,
    input  logic [4:0]        rs2_addr,
    output logic [`XLEN-1:0]  rdata1,
    output logic [`XLEN-1:0]  rdata2,
    input  logic              wen,
    input  logic [4:0]        waddr,
    input  logic [`XLEN-1:0]  wdata
);

    // no storage behind x0
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                if (wen && waddr == 5'(i)) begin
                    regs[i] <= wdata;
                end
            end
        end
    end

    always_comb begin
        rdata1 = '0;
        rdata2 = '0;
        for (int i = 1; i < `NUM_REGS; i++) begin
            if (rs1_addr == 5'(i)) rdata1 = regs[i];
            if (rs2_addr == 5'(i)) rdata2 = regs[i];
        end
    end

endmodule

// ==== verilog/exu.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module exu (
    input  logic [`XLEN-1:0]  pc,
    exu_ctrl_if.exe           ctrl,
    input  logic [`XLEN-1:0]  rdata1,
    input  logic [`XLEN-1:0]  rdata2,
    input  logic              link,
    output logic [`XLEN-1:0]  alu_result,
    output logic [`XLEN-1:0]  wb_data,
    output logic [`XLEN-1:0]  nextpc
);

    logic [`XLEN-1:0] imm_i_sext;
    logic [`XLEN-1:0] imm_j_sext;
    logic [`XLEN-1:0] imm_u_sext;
    logic [`XLEN-1:0] imm_b_sext;
    logic [`XLEN-1:0] alu_src1;
    logic [`XLEN-1:0] alu_src2;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] pc_seq;
    logic [`XLEN-1:0] jal_pc;
    logic [`XLEN-1:0] jalr_sum;
    logic [`XLEN-1:0] br_pc;
    logic             eq;
    logic             lt;
    logic             br_taken;

    assign imm_i_sext = {{(`XLEN-12){ctrl.imm_i[11]}}, ctrl.imm_i};
    assign imm_j_sext = {{(`XLEN-21){ctrl.imm_j[20]}}, ctrl.imm_j};
    assign imm_u_sext = {{(`XLEN-32){ctrl.imm_u[19]}}, ctrl.imm_u, 12'b0};
    assign imm_b_sext = {{(`XLEN-13){ctrl.imm_b[12]}}, ctrl.imm_b};

    assign alu_src1 = ({`XLEN{ctrl.sel_alusrc1[0]}} & rdata1)
                    | ({`XLEN{ctrl.sel_alusrc1[1]}} & pc);

    assign alu_src2 = ({`XLEN{ctrl.sel_alusrc2[0]}} & rdata2)
                    | ({`XLEN{ctrl.sel_alusrc2[1]}} & imm_i_sext)
                    | ({`XLEN{ctrl.sel_alusrc2[2]}} & imm_u_sext);

    alu u_alu (
        .alu_op (ctrl.alu_op        ),
        .src1   (alu_src1           ),
        .src2   (alu_src2           ),
        .word   (ctrl.sel_alures[1] ),
        .result (alu_res            )
    );

    // word results sign-extend from bit 31
    assign alu_result = ({`XLEN{ctrl.sel_alures[0]}} & alu_res)
                      | ({`XLEN{ctrl.sel_alures[1]}} & {{(`XLEN-32){alu_res[31]}}, alu_res[31:0]});

    assign pc_seq   = pc + `XLEN'd4;
    assign jal_pc   = pc + imm_j_sext;
    assign jalr_sum = rdata1 + imm_i_sext;
    assign br_pc    = pc + imm_b_sext;

    assign eq = (rdata1 == rdata2);
    assign lt = ($signed(rdata1) < $signed(rdata2));

    assign br_taken = (ctrl.sel_nextpc[3] &  eq)
                    | (ctrl.sel_nextpc[4] & ~eq)
                    | (ctrl.sel_nextpc[5] &  lt)
                    | (ctrl.sel_nextpc[6] & ~lt);

    // falls back to pc+4 for seq and untaken branches
    assign nextpc = ctrl.sel_nextpc[1] ? jal_pc :
                    ctrl.sel_nextpc[2] ? {jalr_sum[`XLEN-1:1], 1'b0} :
                    br_taken           ? br_pc :
                                         pc_seq;

    // jal/jalr write the return address
    assign wb_data = link ? pc_seq : alu_result;

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              inst_valid,
    input  logic [31:0]       inst,
    output logic [`XLEN-1:0]  pc,
    output logic              wb_en,
    output logic [4:0]        wb_addr,
    output logic [`XLEN-1:0]  wb_data
);

    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [4:0]       rd_addr;
    logic             rf_wen;
    logic             link;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [`XLEN-1:0] nextpc;

    exu_ctrl_if ctrl_if ();

    idu u_idu (
        .inst     (inst        ),
        .ctrl     (ctrl_if.dec ),
        .rs1_addr (rs1_addr    ),
        .rs2_addr (rs2_addr    ),
        .rd_addr  (rd_addr     ),
        .rf_wen   (rf_wen      ),
        .link     (link        )
    );

    regfile u_regfile (
        .clk      (clk      ),
        .arst_n   (arst_n   ),
        .rs1_addr (rs1_addr ),
        .rs2_addr (rs2_addr ),
        .rdata1   (rdata1   ),
        .rdata2   (rdata2   ),
        .wen      (wb_en    ),
        .waddr    (rd_addr  ),
        .wdata    (wb_data  )
    );

    // alu_result only feeds the write-back mux inside exu
    exu u_exu (
        .pc         (pc          ),
        .ctrl       (ctrl_if.exe ),
        .rdata1     (rdata1      ),
        .rdata2     (rdata2      ),
        .link       (link        ),
        .alu_result (            ),
        .wb_data    (wb_data     ),
        .nextpc     (nextpc      )
    );

    // commit port, stalled while no instruction is presented
    assign wb_en   = rf_wen & inst_valid;
    assign wb_addr = rd_addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else if (inst_valid) begin
            pc <= nextpc;
        end
    end

endmodule

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core;

    localparam int PROG_WORDS = 64;
    // five short programs plus resets stay well under 150 cycles
    localparam int MAX_CYCLES = 400;

    logic              clk;
    logic              arst_n;
    logic              inst_valid;
    logic [31:0]       inst;
    logic [`XLEN-1:0]  pc;
    logic              wb_en;
    logic [4:0]        wb_addr;
    logic [`XLEN-1:0]  wb_data;

    logic [31:0]       prog     [PROG_WORDS];
    logic              exp_en   [PROG_WORDS];
    logic [`XLEN-1:0]  exp_data [PROG_WORDS];
    logic [`XLEN-1:0]  exp_npc  [PROG_WORDS];

    logic [31:0]       lfsr;
    int                cycles;
    int                checks;
    int                errors;
    int                test_errors;
    int                tests_run;
    int                tests_failed;
    int                path_steps;
    string             cur_test;

    // commit port as seen mid low phase
    logic [`XLEN-1:0]  s_pc;
    logic              s_en;
    logic [4:0]        s_addr;
    logic [`XLEN-1:0]  s_data;

    rv_core dut0 (
        .clk        (clk        ),
        .arst_n     (arst_n     ),
        .inst_valid (inst_valid ),
        .inst       (inst       ),
        .pc         (pc         ),
        .wb_en      (wb_en      ),
        .wb_addr    (wb_addr    ),
        .wb_data    (wb_data    )
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the core stopped making progress", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] r_word(input logic [6:0] opc, input logic [6:0] f7,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        r_word = {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        i_word = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_word(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        u_word = {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        b_word = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] off);
        j_word = {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        sext12 = {{52{v[11]}}, v};
    endfunction

    function automatic logic [63:0] sext32(input logic [63:0] v);
        sext32 = {{32{v[31]}}, v[31:0]};
    endfunction

    function automatic logic [63:0] slot_pc(input int k);
        slot_pc = `RESET_PC + 64'(4 * k);
    endfunction

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    // filler writes x0 with an immediate taken from the slot
    task automatic clear_prog();
        for (int k = 0; k < PROG_WORDS; k++) begin
            prog[k]     = i_word(`OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'(k));
            exp_en[k]   = 1'b0;
            exp_data[k] = '0;
            exp_npc[k]  = slot_pc(k + 1);
        end
    endtask

    task automatic place(input int k, input logic [31:0] w, input logic en,
                         input logic [63:0] data);
        prog[k]     = w;
        exp_en[k]   = en;
        exp_data[k] = data;
    endtask

    // op with rd = slot + 1, sources x1 and x2
    task automatic op_slot(input int k, input logic [6:0] f7, input logic [2:0] f3,
                           input logic [63:0] data);
        place(k, r_word(`OPC_OP, f7, f3, 5'(k + 1), 5'd1, 5'd2), 1'b1, data);
    endtask

    // branch at k, filler at k+1, paths meet again at k+2
    task automatic branch_slot(input int k, input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic [63:0] v1,
                               input logic [63:0] v2);
        logic take;
        case (f3)
            3'b000:  take = (v1 == v2);
            3'b001:  take = (v1 != v2);
            3'b100:  take = ($signed(v1) < $signed(v2));
            default: take = ($signed(v1) >= $signed(v2));
        endcase
        place(k, b_word(f3, rs1, rs2, 13'd8), 1'b0, '0);
        exp_npc[k] = take ? slot_pc(k + 2) : slot_pc(k + 1);
        path_steps += take ? 1 : 2;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic step(input logic valid);
        logic [63:0] off;
        @(negedge clk);
        off        = pc - `RESET_PC;
        inst_valid = valid;
        inst       = (off < 64'(4 * PROG_WORDS)) ? prog[off[7:2]] : 32'h0;
        #5;
        s_pc   = pc;
        s_en   = wb_en;
        s_addr = wb_addr;
        s_data = wb_data;
    endtask

    task automatic run_prog(input int n);
        int          k;
        logic [63:0] want_pc;
        want_pc = `RESET_PC;
        for (int i = 0; i < n; i++) begin
            step(1'b1);
            check("pc", want_pc, s_pc);
            k = int'((want_pc - `RESET_PC) >> 2);
            check("wb_en", 64'(exp_en[k]), 64'(s_en));
            if (exp_en[k]) begin
                check("wb_addr", 64'(prog[k][11:7]), 64'(s_addr));
                check("wb_data", exp_data[k], s_data);
            end
            want_pc = exp_npc[k];
        end
    endtask

    task automatic reset_and_stall();
        start_test("reset_and_stall");
        clear_prog();
        // slot 4 writes x1 too, so a stall there has a write to suppress
        for (int k = 0; k < 5; k++) begin
            place(k, i_word(`OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'(k + 1)), 1'b1, 64'(k + 1));
        end
        apply_reset();
        check("pc after reset", `RESET_PC, pc);
        repeat (4) begin
            step(1'b0);
            check("stalled pc", `RESET_PC, s_pc);
            check("stalled wb_en", 64'd0, 64'(s_en));
        end
        run_prog(4);
        repeat (2) begin
            step(1'b0);
            check("pc held", slot_pc(4), s_pc);
            check("held wb_en", 64'd0, 64'(s_en));
        end
        step(1'b1);
        check("resumed pc", slot_pc(4), s_pc);
        check("resumed wb_en", 64'd1, 64'(s_en));
        check("resumed wb_data", 64'd5, s_data);
        finish_test();
    endtask

    task automatic alu_ops();
        logic [63:0] ra;
        logic [63:0] rb;
        logic [63:0] ru;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] u;
        start_test("alu_ops");
        clear_prog();
        rand_bits(12, ra);
        rand_bits(12, rb);
        rand_bits(20, ru);
        a = sext12(ra[11:0]);
        b = sext12(rb[11:0]);
        u = {{32{ru[19]}}, ru[19:0], 12'h000};
        place(0, i_word(`OPC_OP_IMM, 3'b000, 5'd1, 5'd0, ra[11:0]), 1'b1, a);
        place(1, i_word(`OPC_OP_IMM, 3'b000, 5'd2, 5'd0, rb[11:0]), 1'b1, b);
        op_slot(2, 7'h00, 3'b000, a + b);
        op_slot(3, 7'h20, 3'b000, a - b);
        op_slot(4, 7'h00, 3'b100, a ^ b);
        op_slot(5, 7'h00, 3'b110, a | b);
        op_slot(6, 7'h00, 3'b111, a & b);
        op_slot(7, 7'h00, 3'b010, 64'($signed(a) < $signed(b)));
        op_slot(8, 7'h00, 3'b011, 64'(a < b));
        op_slot(9, 7'h00, 3'b001, a << b[5:0]);
        op_slot(10, 7'h00, 3'b101, a >> b[5:0]);
        op_slot(11, 7'h20, 3'b101, $signed(a) >>> b[5:0]);
        place(12, u_word(`OPC_LUI, 5'd13, ru[19:0]), 1'b1, u);
        place(13, u_word(`OPC_AUIPC, 5'd14, ru[19:0]), 1'b1, slot_pc(13) + u);
        apply_reset();
        run_prog(14);
        finish_test();
    endtask

    task automatic word_ops();
        logic [63:0] ra;
        logic [63:0] rb;
        logic [63:0] a;
        logic [63:0] c;
        start_test("word_ops");
        clear_prog();
        rand_bits(12, ra);
        rand_bits(12, rb);
        a = sext12(ra[11:0]);
        c = 64'h7fff_f000 + sext12(12'h7ff);
        place(0, i_word(`OPC_OP_IMM, 3'b000, 5'd1, 5'd0, ra[11:0]), 1'b1, a);
        place(1, u_word(`OPC_LUI, 5'd2, 20'h7ffff), 1'b1, 64'h7fff_f000);
        place(2, i_word(`OPC_OP_IMM, 3'b000, 5'd3, 5'd2, 12'h7ff), 1'b1, c);
        // c + c wraps past bit 31
        place(3, r_word(`OPC_OP_32, 7'h00, 3'b000, 5'd4, 5'd3, 5'd3), 1'b1, sext32(c + c));
        place(4, i_word(`OPC_OP_IMM_32, 3'b000, 5'd5, 5'd1, rb[11:0]), 1'b1,
              sext32(a + sext12(rb[11:0])));
        place(5, r_word(`OPC_OP_32, 7'h20, 3'b000, 5'd6, 5'd1, 5'd3), 1'b1, sext32(a - c));
        place(6, i_word(`OPC_OP_IMM_32, 3'b000, 5'd7, 5'd3, 12'h7ff), 1'b1,
              sext32(c + 64'h7ff));
        apply_reset();
        run_prog(7);
        finish_test();
    endtask

    task automatic branch_ops();
        logic [63:0] ra;
        logic [63:0] rb;
        logic [63:0] a;
        logic [63:0] b;
        start_test("branch_ops");
        clear_prog();
        rand_bits(11, ra);
        rand_bits(11, rb);
        // x1 negative, x2 positive
        a = sext12({1'b1, ra[10:0]});
        b = sext12({1'b0, rb[10:0]});
        place(0, i_word(`OPC_OP_IMM, 3'b000, 5'd1, 5'd0, a[11:0]), 1'b1, a);
        place(1, i_word(`OPC_OP_IMM, 3'b000, 5'd2, 5'd0, b[11:0]), 1'b1, b);
        path_steps = 3;
        branch_slot(2, 3'b000, 5'd1, 5'd2, a, b);
        branch_slot(4, 3'b001, 5'd1, 5'd2, a, b);
        branch_slot(6, 3'b100, 5'd1, 5'd2, a, b);
        branch_slot(8, 3'b101, 5'd1, 5'd2, a, b);
        branch_slot(10, 3'b000, 5'd1, 5'd1, a, a);
        branch_slot(12, 3'b001, 5'd1, 5'd1, a, a);
        branch_slot(14, 3'b100, 5'd2, 5'd1, b, a);
        branch_slot(16, 3'b101, 5'd2, 5'd1, b, a);
        place(18, i_word(`OPC_OP_IMM, 3'b000, 5'd3, 5'd1, 12'd0), 1'b1, a);
        apply_reset();
        run_prog(path_steps);
        finish_test();
    endtask

    task automatic jumps_and_x0();
        logic [63:0] t;
        start_test("jumps_and_x0");
        clear_prog();
        place(0, j_word(5'd2, 21'd12), 1'b1, slot_pc(1));
        exp_npc[0] = slot_pc(0) + 64'd12;
        place(3, u_word(`OPC_AUIPC, 5'd1, 20'h0), 1'b1, slot_pc(3));
        // odd offset, target bit 0 cleared
        place(4, i_word(`OPC_JALR, 3'b000, 5'd3, 5'd1, 12'd13), 1'b1, slot_pc(5));
        t          = slot_pc(3) + 64'd13;
        exp_npc[4] = {t[63:1], 1'b0};
        place(6, i_word(`OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'd5), 1'b0, '0);
        place(7, r_word(`OPC_OP, 7'h00, 3'b000, 5'd4, 5'd0, 5'd0), 1'b1, 64'd0);
        place(8, r_word(`OPC_OP, 7'h00, 3'b000, 5'd5, 5'd2, 5'd0), 1'b1, slot_pc(1));
        apply_reset();
        run_prog(6);
        finish_test();
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        lfsr         = 32'hdd27_d0a0;
        cycles       = 0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        path_steps   = 0;
        reset_and_stall();
        alu_ops();
        word_ops();
        branch_ops();
        jumps_and_x0();
        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== rv_core.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/exu_ctrl_if.sv
verilog/alu.sv
verilog/idu.sv
verilog/regfile.sv
verilog/exu.sv
verilog/rv_core.sv
tb/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_pkg.sv
      - verilog/exu_ctrl_if.sv
      - verilog/alu.sv
      - verilog/idu.sv
      - verilog/regfile.sv
      - verilog/exu.sv
      - verilog/rv_core.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - tb/tb_rv_core.sv
